//--- sim.f
softermax_pkg.sv
skid_buffer.sv
fixed_range_reduction.sv
fixed_unsigned_cast.sv
softermax_lpw_reciprocal.sv
softermax_recip_top.sv
tb_clock_gen.sv
tb_softermax_recip.sv

//--- Makefile
# Verilator build and run for the softermax reciprocal testbench

VERILATOR ?= verilator
TOP       ?= tb_softermax_recip
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
JOBS      ?= 4

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

//--- tb_softermax_recip.sv
// Testbench for the softermax reciprocal unit
//   Random and directed Q4.4 stimulus, random back-pressure
//   Reference model built from the package table functions
//   Scoreboard queue, compare tasks and latency check

`timescale 1ns/1ps

module tb_softermax_recip
    import softermax_pkg::*;
();

    localparam logic [31:0] SEED = 32'haf40_b6be;
    localparam int WAIT_LIMIT = 2000;
    localparam int MANT_FRAC  = DEF_IN_WIDTH - 1;
    localparam int SLOPE_FRAC = DEF_OUT_WIDTH;
    localparam int PROD_FRAC  = MANT_FRAC + SLOPE_FRAC;
    localparam int ENTRY_BITS = msb_index_width(DEF_ENTRIES);

    logic                     clk;
    logic                     rst_n;
    logic [DEF_IN_WIDTH-1:0]  in_data;
    logic                     in_valid;
    logic                     in_ready;
    logic [DEF_OUT_WIDTH-1:0] out_data;
    logic                     out_valid;
    logic                     out_ready = 1'b1;

    int   seed;
    int   bp_seed;
    logic stall_en;
    int   sent_count;
    int   recv_count = 0;
    int   slope_tab [DEF_ENTRIES];
    int   intercept_tab [DEF_ENTRIES];
    logic [DEF_OUT_WIDTH-1:0] exp_q [$];

    tb_clock_gen #(.PERIOD_NS(4.0)) u_clk (.clk(clk));

    softermax_recip_top DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_data  (in_data),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .out_data (out_data),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_data(input string name, input logic [DEF_OUT_WIDTH-1:0] got,
                              input logic [DEF_OUT_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s expected %02h observed %02h", $time, name, exp, got);
            fail_run("Output value mismatch");
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("ERR %0t %s expected %0d observed %0d", $time, name, exp, got);
            fail_run("Count mismatch");
        end
    endtask

    // Segment i spans [1 + i/ENTRIES, 1 + (i+1)/ENTRIES)
    task automatic build_tables();
        real x1;
        real x2;
        for (int i = 0; i < DEF_ENTRIES; i++) begin
            x1 = 1.0 + real'(i) / DEF_ENTRIES;
            x2 = 1.0 + real'(i + 1) / DEF_ENTRIES;
            slope_tab[i]     = lpw_slope(x1, x2, SLOPE_FRAC);
            intercept_tab[i] = lpw_intercept(x1, x2, PROD_FRAC);
        end
    endtask

    // Reduce to [1, 2), evaluate the segment line, rescale, floor and saturate
    function automatic logic [DEF_OUT_WIDTH-1:0] model_recip(input logic [DEF_IN_WIDTH-1:0] x);
        int msb;
        int mant;
        int idx;
        int approx;
        int shift;
        int scaled;
        int code;
        if (x == 0) begin
            return '1;
        end
        msb = 0;
        for (int i = 0; i < DEF_IN_WIDTH; i++) begin
            if (x[i]) begin
                msb = i;
            end
        end
        mant   = int'(x) << (MANT_FRAC - msb);
        idx    = (mant >> (MANT_FRAC - ENTRY_BITS)) % DEF_ENTRIES;
        approx = mant * slope_tab[idx] + intercept_tab[idx];
        shift  = DEF_IN_FRAC_WIDTH - msb;
        scaled = (shift >= 0) ? (approx <<< shift) : (approx >>> (-shift));
        code   = scaled >>> (PROD_FRAC - DEF_OUT_FRAC_WIDTH);
        if (code >= (1 << DEF_OUT_WIDTH)) begin
            return '1;
        end
        return DEF_OUT_WIDTH'(code);
    endfunction

    // Called on a rising edge, returns on the edge of acceptance
    task automatic send_item(input logic [DEF_IN_WIDTH-1:0] x,
                             input logic [DEF_OUT_WIDTH-1:0] exp);
        int waited;
        waited = 0;
        in_data  <= x;
        in_valid <= 1'b1;
        @(posedge clk);
        while (!in_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_run("Timeout waiting for in_ready");
            end
            @(posedge clk);
        end
        exp_q.push_back(exp);
    endtask

    task automatic idle_cycle();
        in_valid <= 1'b0;
        @(posedge clk);
    endtask

    task automatic wait_drain(input string what);
        int waited;
        waited = 0;
        in_valid <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_run({"Timeout waiting for results of ", what});
            end
        end
    endtask

    // Random back-pressure on the output side
    always @(posedge clk) begin
        if (stall_en) begin
            out_ready <= ($random(bp_seed) & 1) != 0;
        end else begin
            out_ready <= 1'b1;
        end
    end

    // Input transfers as seen at the DUT boundary
    always @(posedge clk) begin
        if (rst_n && in_valid && in_ready) begin
            sent_count++;
        end
    end

    // Scoreboard
    always @(posedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                fail_run("Output transfer with no input pending");
            end else begin
                check_data("out_data", out_data, exp_q.pop_front());
                recv_count++;
            end
        end
    end

    initial begin
        int cycles;
        logic [DEF_IN_WIDTH-1:0] x;
        seed       = SEED;
        bp_seed    = SEED ^ 32'h0f0f_0f0f;
        stall_en   = 1'b0;
        sent_count = 0;
        rst_n      = 1'b0;
        in_data    = '0;
        in_valid   = 1'b0;
        build_tables();

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        if (!in_ready || out_valid) begin
            fail_run("Pipeline not idle after reset release");
        end

        // Nonzero random inputs at full rate
        for (int i = 0; i < 200; i++) begin
            x = DEF_IN_WIDTH'(1 + {$random(seed)} % 255);
            send_item(x, model_recip(x));
        end

        // Zero, saturation and powers of two with values read off the Q formats
        send_item(8'h00, 8'hff);
        send_item(8'h01, 8'hff);
        send_item(8'h02, 8'hff);
        send_item(8'h10, 8'h20);
        send_item(8'h20, 8'h10);
        send_item(8'h08, 8'h40);
        send_item(8'h40, 8'h08);
        wait_drain("directed inputs");

        // Single item through an empty pipeline
        send_item(8'h28, model_recip(8'h28));
        in_valid <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > 20) begin
                fail_run("Timeout waiting for out_valid in latency test");
            end
        end while (!out_valid);
        check_count("latency", cycles, 5);
        wait_drain("latency input");

        // Gaps on the input side, stalls on the output side
        stall_en <= 1'b1;
        for (int i = 0; i < 300; i++) begin
            x = DEF_IN_WIDTH'($random(seed));
            if (($random(seed) & 3) == 0) begin
                idle_cycle();
            end
            send_item(x, model_recip(x));
        end
        wait_drain("back-pressure inputs");
        stall_en <= 1'b0;
        check_count("result count", recv_count, sent_count);

        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- tb_clock_gen.sv
// Testbench clock source
//   Free running clock, 50 percent duty cycle

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

//--- softermax_recip_top.sv
// Top level of the softermax reciprocal unit
//   Q4.4 input stream, Q3.5 output stream
//   Reciprocal pipeline built with the package defaults

`timescale 1ns/1ps

module softermax_recip_top
    import softermax_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic [DEF_IN_WIDTH-1:0]  in_data,
    input  logic                     in_valid,
    output logic                     in_ready,

    output logic [DEF_OUT_WIDTH-1:0] out_data,
    output logic                     out_valid,
    input  logic                     out_ready
);

    softermax_lpw_reciprocal #(
        .ENTRIES       (DEF_ENTRIES),
        .IN_WIDTH      (DEF_IN_WIDTH),
        .IN_FRAC_WIDTH (DEF_IN_FRAC_WIDTH),
        .OUT_WIDTH     (DEF_OUT_WIDTH),
        .OUT_FRAC_WIDTH(DEF_OUT_FRAC_WIDTH)
    ) u_recip (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_data  (in_data),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .out_data (out_data),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

endmodule

//--- softermax_lpw_reciprocal.sv
// Streaming 1/x for unsigned fixed point inputs
//   Range reduction into [1, 2)
//   Piecewise linear slope and intercept tables
//   Shift back by the reduction exponent, floor and saturate
//   Five skid buffer stages, parameter checks and output assertion

`timescale 1ns/1ps

module softermax_lpw_reciprocal
    import softermax_pkg::*;
#(
    parameter int ENTRIES        = 8,
    parameter int IN_WIDTH       = 8,
    parameter int IN_FRAC_WIDTH  = 4,
    parameter int OUT_WIDTH      = 8,
    parameter int OUT_FRAC_WIDTH = 5
) (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic [IN_WIDTH-1:0]  in_data,
    input  logic                 in_valid,
    output logic                 in_ready,

    output logic [OUT_WIDTH-1:0] out_data,
    output logic                 out_valid,
    input  logic                 out_ready
);

    localparam int ENTRIES_WIDTH = msb_index_width(ENTRIES);

    // Reduced mantissa in Q1.(IN_WIDTH-1)
    localparam int RR_FRAC_WIDTH = IN_WIDTH - 1;

    // Slope precision sets the output precision
    localparam int SLOPE_FRAC_WIDTH = OUT_WIDTH;
    localparam int SLOPE_WIDTH      = 1 + SLOPE_FRAC_WIDTH;

    localparam int MULT_WIDTH      = IN_WIDTH + SLOPE_WIDTH;
    localparam int MULT_FRAC_WIDTH = RR_FRAC_WIDTH + SLOPE_FRAC_WIDTH;

    // Intercept reaches up to 2, so two integer bits
    localparam int INTERCEPT_FRAC_WIDTH = MULT_FRAC_WIDTH;
    localparam int INTERCEPT_WIDTH      = 2 + INTERCEPT_FRAC_WIDTH;

    localparam int LPW_WIDTH      = MULT_WIDTH + 1;
    localparam int LPW_FRAC_WIDTH = MULT_FRAC_WIDTH;

    // Headroom so the left shift never loses bits
    localparam int IN_INT_WIDTH = IN_WIDTH - IN_FRAC_WIDTH;
    localparam int EXTRA_WIDTH  = (IN_INT_WIDTH > IN_FRAC_WIDTH) ? IN_INT_WIDTH : IN_FRAC_WIDTH;
    localparam int RECIP_WIDTH  = LPW_WIDTH + EXTRA_WIDTH;

    localparam int MSB_WIDTH   = msb_index_width(IN_WIDTH);
    localparam int SHIFT_WIDTH = MSB_WIDTH + 1;

    initial begin
        assert (ENTRIES >= 4);
        assert (2 ** ENTRIES_WIDTH == ENTRIES);
        assert (ENTRIES_WIDTH <= RR_FRAC_WIDTH);
        assert (IN_WIDTH > IN_FRAC_WIDTH);
        assert (IN_FRAC_WIDTH >= ENTRIES_WIDTH);
        assert (OUT_WIDTH > OUT_FRAC_WIDTH);
        assert (OUT_FRAC_WIDTH >= ENTRIES_WIDTH);
        assert (OUT_FRAC_WIDTH <= LPW_FRAC_WIDTH);
    end

    typedef struct packed {
        logic [IN_WIDTH-1:0]  mant;
        logic [MSB_WIDTH-1:0] msb;
        logic                 zero;
    } rr_t;

    typedef struct packed {
        logic signed [MULT_WIDTH-1:0] prod;
        logic [ENTRIES_WIDTH-1:0]     idx;
        logic [MSB_WIDTH-1:0]         msb;
        logic                         zero;
    } mult_t;

    typedef struct packed {
        logic signed [LPW_WIDTH-1:0]   approx;
        logic signed [SHIFT_WIDTH-1:0] shift;
        logic                          zero;
    } lpw_t;

    typedef struct packed {
        logic [RECIP_WIDTH-1:0] recip;
        logic                   zero;
    } recip_t;

    typedef struct packed {
        logic [OUT_WIDTH-1:0] data;
    } out_t;

    logic signed [SLOPE_WIDTH-1:0] slope_lut     [ENTRIES];
    logic [INTERCEPT_WIDTH-1:0]    intercept_lut [ENTRIES];

    // Segment i covers [1 + i/ENTRIES, 1 + (i+1)/ENTRIES)
    initial begin
        for (int i = 0; i < ENTRIES; i++) begin
            real x1;
            real x2;
            x1 = 1.0 + real'(i) / ENTRIES;
            x2 = 1.0 + real'(i + 1) / ENTRIES;
            slope_lut[i]     = SLOPE_WIDTH'(lpw_slope(x1, x2, SLOPE_FRAC_WIDTH));
            intercept_lut[i] = INTERCEPT_WIDTH'(lpw_intercept(x1, x2, INTERCEPT_FRAC_WIDTH));
        end
    end

    rr_t    rr_d, rr_q;
    mult_t  mult_d, mult_q;
    lpw_t   lpw_d, lpw_q;
    recip_t recip_d, recip_q;
    out_t   out_d, out_q;

    logic rr_valid, rr_ready;
    logic mult_valid, mult_ready;
    logic lpw_valid, lpw_ready;
    logic recip_valid, recip_ready;

    logic signed [RECIP_WIDTH-1:0] lpw_ext;
    logic [OUT_WIDTH-1:0]          cast_out;

    fixed_range_reduction #(
        .WIDTH(IN_WIDTH)
    ) u_range_reduce (
        .data_a   (in_data),
        .data_out (rr_d.mant),
        .msb_index(rr_d.msb),
        .not_found(rr_d.zero)
    );

    skid_buffer #(.T(rr_t)) u_rr_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .data_in       (rr_d),
        .data_in_valid (in_valid),
        .data_in_ready (in_ready),
        .data_out      (rr_q),
        .data_out_valid(rr_valid),
        .data_out_ready(rr_ready)
    );

    // Table index from the top fraction bits of the mantissa
    always_comb begin
        mult_d.idx  = rr_q.mant[IN_WIDTH-2 -: ENTRIES_WIDTH];
        mult_d.prod = $signed({1'b0, rr_q.mant}) * slope_lut[mult_d.idx];
        mult_d.msb  = rr_q.msb;
        mult_d.zero = rr_q.zero;
    end

    skid_buffer #(.T(mult_t)) u_mult_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .data_in       (mult_d),
        .data_in_valid (rr_valid),
        .data_in_ready (rr_ready),
        .data_out      (mult_q),
        .data_out_valid(mult_valid),
        .data_out_ready(mult_ready)
    );

    // x = m * 2^(msb - IN_FRAC_WIDTH), so 1/x scales by 2^(IN_FRAC_WIDTH - msb)
    always_comb begin
        lpw_d.approx = mult_q.prod + $signed({1'b0, intercept_lut[mult_q.idx]});
        lpw_d.shift  = SHIFT_WIDTH'(IN_FRAC_WIDTH) - {1'b0, mult_q.msb};
        lpw_d.zero   = mult_q.zero;
    end

    skid_buffer #(.T(lpw_t)) u_lpw_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .data_in       (lpw_d),
        .data_in_valid (mult_valid),
        .data_in_ready (mult_ready),
        .data_out      (lpw_q),
        .data_out_valid(lpw_valid),
        .data_out_ready(lpw_ready)
    );

    assign lpw_ext = RECIP_WIDTH'(lpw_q.approx);

    always_comb begin
        recip_d.zero = lpw_q.zero;
        if (lpw_q.shift >= 0) begin
            recip_d.recip = lpw_ext <<< lpw_q.shift;
        end else begin
            recip_d.recip = lpw_ext >>> (-lpw_q.shift);
        end
    end

    skid_buffer #(.T(recip_t)) u_recip_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .data_in       (recip_d),
        .data_in_valid (lpw_valid),
        .data_in_ready (lpw_ready),
        .data_out      (recip_q),
        .data_out_valid(recip_valid),
        .data_out_ready(recip_ready)
    );

    fixed_unsigned_cast #(
        .IN_WIDTH      (RECIP_WIDTH),
        .IN_FRAC_WIDTH (LPW_FRAC_WIDTH),
        .OUT_WIDTH     (OUT_WIDTH),
        .OUT_FRAC_WIDTH(OUT_FRAC_WIDTH)
    ) u_cast (
        .in_data (recip_q.recip),
        .out_data(cast_out)
    );

    // 1/0 reported as the largest code
    assign out_d.data = recip_q.zero ? '1 : cast_out;

    skid_buffer #(.T(out_t)) u_out_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .data_in       (out_d),
        .data_in_valid (recip_valid),
        .data_in_ready (recip_ready),
        .data_out      (out_q),
        .data_out_valid(out_valid),
        .data_out_ready(out_ready)
    );

    assign out_data = out_q.data;

    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

//--- fixed_unsigned_cast.sv
// Unsigned fixed point cast
//   Floor truncation of surplus fraction bits
//   Saturation to all ones when integer bits overflow

`timescale 1ns/1ps

module fixed_unsigned_cast #(
    parameter int IN_WIDTH       = 16,
    parameter int IN_FRAC_WIDTH  = 8,
    parameter int OUT_WIDTH      = 8,
    parameter int OUT_FRAC_WIDTH = 4
) (
    input  logic [IN_WIDTH-1:0]  in_data,
    output logic [OUT_WIDTH-1:0] out_data
);

    localparam int DROP = IN_FRAC_WIDTH - OUT_FRAC_WIDTH;
    localparam int KEPT = IN_WIDTH - DROP;

    logic [KEPT-1:0] floored;

    // Dropping low bits of an unsigned value is a floor
    assign floored = in_data[IN_WIDTH-1:DROP];

    generate
        if (KEPT > OUT_WIDTH) begin : g_sat
            assign out_data = (|floored[KEPT-1:OUT_WIDTH]) ? '1 : floored[OUT_WIDTH-1:0];
        end else begin : g_pad
            assign out_data = OUT_WIDTH'(floored);
        end
    endgenerate

endmodule

//--- fixed_range_reduction.sv
// Range reduction for unsigned fixed point
//   Leading one detection
//   Normalising left shift so the leading one lands in the top bit
//   Zero input flag

`timescale 1ns/1ps

module fixed_range_reduction
    import softermax_pkg::*;
#(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0]                  data_a,
    output logic [WIDTH-1:0]                  data_out,
    output logic [msb_index_width(WIDTH)-1:0] msb_index,
    output logic                              not_found
);

    localparam int MSB_WIDTH = msb_index_width(WIDTH);

    // Highest set bit wins
    always_comb begin
        msb_index = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (data_a[i]) begin
                msb_index = MSB_WIDTH'(i);
            end
        end
    end

    // Result reads as Q1.(WIDTH-1)
    assign data_out  = data_a << (WIDTH - 1 - int'(msb_index));
    assign not_found = ~|data_a;

endmodule

//--- skid_buffer.sv
// Single pipeline stage with valid/ready handshake
//   Main register plus skid register
//   Registered ready, one transfer per cycle when not stalled
//   Payload type set by parameter

`timescale 1ns/1ps

module skid_buffer #(
    parameter type T = logic [7:0]
) (
    input  logic clk,
    input  logic rst_n,

    input  T     data_in,
    input  logic data_in_valid,
    output logic data_in_ready,

    output T     data_out,
    output logic data_out_valid,
    input  logic data_out_ready
);

    T     main_data;
    T     skid_data;
    logic main_valid;
    logic skid_valid;
    logic main_free;
    logic in_fire;
    logic main_load;
    logic skid_load;

    // Main slot can take a new item this cycle
    assign main_free = data_out_ready | ~main_valid;
    assign in_fire   = data_in_valid & data_in_ready;
    assign main_load = main_free & (skid_valid | in_fire);
    // Stalled output, so the incoming item parks in the skid slot
    assign skid_load = in_fire & ~main_free;

    assign data_in_ready  = ~skid_valid;
    assign data_out       = main_data;
    assign data_out_valid = main_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            if (main_free) begin
                main_valid <= skid_valid | in_fire;
            end
            if (main_free && skid_valid) begin
                skid_valid <= 1'b0;
            end else if (skid_load) begin
                skid_valid <= 1'b1;
            end
        end
    end

    // Skid slot drains first to keep order
    always_ff @(posedge clk) begin
        if (main_load) begin
            main_data <= skid_valid ? skid_data : data_in;
        end
        if (skid_load) begin
            skid_data <= data_in;
        end
    end

    // Upstream holds its item while this stage is full
    a_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
        data_in_valid && !data_in_ready |=> data_in_valid && $stable(data_in));

endmodule

//--- softermax_pkg.sv
// Shared definitions for the softermax reciprocal unit
//   Default stream formats and table size
//   Table entry functions for the piecewise linear 1/x approximation
//   Width helper for index and shift fields

package softermax_pkg;

    // Input in Q4.4, output in Q3.5
    localparam int DEF_IN_WIDTH       = 8;
    localparam int DEF_IN_FRAC_WIDTH  = 4;
    localparam int DEF_OUT_WIDTH      = 8;
    localparam int DEF_OUT_FRAC_WIDTH = 5;

    // Power of two, at least 4
    localparam int DEF_ENTRIES = 8;

    // Secant slope of 1/x over [x1, x2], truncated toward zero
    function automatic int lpw_slope(real x1, real x2, int frac_width);
        real y1;
        real y2;
        real m;
        y1 = 1.0 / x1;
        y2 = 1.0 / x2;
        m  = (y2 - y1) / (x2 - x1);
        return $rtoi(m * (2.0 ** frac_width));
    endfunction

    // Line value at x = 0 for the same secant, truncated toward zero
    function automatic int lpw_intercept(real x1, real x2, int frac_width);
        real y1;
        real y2;
        real m;
        real c;
        y1 = 1.0 / x1;
        y2 = 1.0 / x2;
        m  = (y2 - y1) / (x2 - x1);
        c  = y1 - (m * x1);
        return $rtoi(c * (2.0 ** frac_width));
    endfunction

    // Bits needed to index a field of the given width
    function automatic int msb_index_width(int width);
        return $clog2(width);
    endfunction

endpackage
